//--- Bender.yml
package:
  name: mipsCore

sources:
  - logic/coreDefsPkg.sv
  - logic/wbPkg.sv
  - logic/aluUnit.sv
  - logic/regFile.sv
  - logic/ctrlFsm.sv
  - logic/dataPath.sv
  - logic/mipsCore.sv
  - target: test
    files:
      - tb/mipsCoreTb.sv

//--- logic/aluUnit.sv
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
    input  coreDefsPkg::word_t  a,
    input  coreDefsPkg::word_t  b,
    input  coreDefsPkg::aluOp_t op,
    output coreDefsPkg::word_t  result,
    output coreDefsPkg::flags_t flags
);
    import coreDefsPkg::*;

    word_t sum, diff;
    logic  lessThan, overflow;

    assign sum      = a + b;
    assign diff     = a - b;
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            aluAdd:  result = sum;
            aluSub:  result = diff;
            aluAnd:  result = a & b;
            aluSlt:  result = {{(dataWidth-1){1'b0}}, lessThan};
            default: result = a; // pass
        endcase
    end

    // signed overflow from operand and result signs
    always_comb begin
        case (op)
            aluAdd:  overflow = (a[dataWidth-1] == b[dataWidth-1])
                             && (sum[dataWidth-1] != a[dataWidth-1]);
            aluSub:  overflow = (a[dataWidth-1] != b[dataWidth-1])
                             && (diff[dataWidth-1] != a[dataWidth-1]);
            default: overflow = 1'b0;
        endcase
    end

    assign flags.overflow = overflow;
    assign flags.zero     = (result == '0);

endmodule

`default_nettype wire

//--- logic/coreDefsPkg.sv
`default_nettype none

package coreDefsPkg;

    localparam int dataWidth = 32;

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [4:0] regAddr_t;

    // kept MIPS opcodes only
    typedef enum logic [5:0] {
        rFormat = 6'h00,
        j       = 6'h02,
        beq     = 6'h04,
        bne     = 6'h05,
        addi    = 6'h08,
        addiu   = 6'h09,
        slti    = 6'h0a,
        lui     = 6'h0f,
        lw      = 6'h23,
        sw      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnSlt = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {aluPass, aluAdd, aluSub, aluAnd, aluSlt} aluOp_t;

    typedef enum logic {srcAPc, srcAReg} aluSrcA_t;
    typedef enum logic [1:0] {srcBReg, srcBFour, srcBImm, srcBImmShift} aluSrcB_t;
    typedef enum logic {dstRt, dstRd} regDst_t;
    typedef enum logic [1:0] {wbAluOut, wbMem, wbSlt, wbLui} wbSrc_t;
    typedef enum logic [2:0] {pcAluResult, pcAluOut, pcJump, pcOvfVector, pcOpcVector} pcSrc_t;

    typedef struct packed {
        logic     pcWrite;
        logic     irWrite;
        logic     regWrite;
        logic     abWrite;
        logic     aluOutWrite;
        logic     mdrWrite;
        aluOp_t   aluOp;
        aluSrcA_t aluSrcA;
        aluSrcB_t aluSrcB;
        regDst_t  regDst;
        wbSrc_t   wbSrc;
        pcSrc_t   pcSrc;
        logic     busReq;
        logic     busWe;
        logic     busAdrFromAlu; // else address comes from PC
    } ctrlWord_t;

    typedef struct packed {
        logic zero;
        logic overflow;
    } flags_t;

endpackage

`default_nettype wire

//--- logic/ctrlFsm.sv
`timescale 1ns/1ns
`default_nettype none

module ctrlFsm (
    input  logic                   clk,
    input  logic                   reset,
    input  coreDefsPkg::opcode_t   opcode,
    input  coreDefsPkg::funct_t    funct,
    input  coreDefsPkg::flags_t    flags,
    input  logic                   busAck,
    output coreDefsPkg::ctrlWord_t ctrl
);
    import coreDefsPkg::*;

    typedef enum logic [2:0] {
        fetch,
        decode,
        execute,
        aluWriteBack,
        memAccess,
        loadWriteBack,
        trapOverflow,
        trapOpcode
    } state_t;

    state_t   state, nextState;
    logic     started;
    logic     isRType, functOk, trapsOnOvf, ovfTrap;
    aluOp_t   execOp;
    aluSrcB_t execSrcB;

    assign isRType    = (opcode == rFormat);
    assign functOk    = funct inside {fnAdd, fnSub, fnAnd, fnSlt};
    assign trapsOnOvf = (opcode == addi) || (isRType && funct inside {fnAdd, fnSub});
    assign ovfTrap    = trapsOnOvf && flags.overflow; // addiu never traps
    assign execSrcB   = (isRType || opcode == beq || opcode == bne) ? srcBReg : srcBImm;

    always_comb begin
        if (isRType) begin
            case (funct)
                fnSub:   execOp = aluSub;
                fnAnd:   execOp = aluAnd;
                fnSlt:   execOp = aluSlt;
                default: execOp = aluAdd;
            endcase
        end else if (opcode == beq || opcode == bne) begin
            execOp = aluSub; // compare through zero flag
        end else if (opcode == slti) begin
            execOp = aluSlt;
        end else begin
            execOp = aluAdd;
        end
    end

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = aluPass;
        nextState  = state;
        case (state)
            fetch: begin
                ctrl.busReq  = started; // bus stays idle the first cycle out of reset
                ctrl.aluSrcA = srcAPc;
                ctrl.aluSrcB = srcBFour;
                ctrl.aluOp   = aluAdd;
                ctrl.pcSrc   = pcAluResult;
                if (busAck) begin
                    ctrl.irWrite = 1'b1;
                    ctrl.pcWrite = 1'b1;
                    nextState    = decode;
                end
            end
            decode: begin
                ctrl.abWrite     = 1'b1;
                ctrl.aluOutWrite = 1'b1; // speculative branch target
                ctrl.aluSrcA     = srcAPc;
                ctrl.aluSrcB     = srcBImmShift;
                ctrl.aluOp       = aluAdd;
                nextState        = execute;
            end
            execute: begin
                ctrl.aluSrcA = srcAReg;
                ctrl.aluSrcB = execSrcB;
                ctrl.aluOp   = execOp;
                nextState    = fetch;
                case (opcode)
                    rFormat: begin
                        ctrl.aluOutWrite = 1'b1;
                        nextState        = functOk ? aluWriteBack : trapOpcode;
                    end
                    addi, addiu: begin
                        ctrl.aluOutWrite = 1'b1;
                        nextState        = aluWriteBack;
                    end
                    lw, sw: begin
                        ctrl.aluOutWrite = 1'b1; // effective address
                        nextState        = memAccess;
                    end
                    slti: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = dstRt;
                        ctrl.wbSrc    = wbSlt;
                    end
                    lui: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = dstRt;
                        ctrl.wbSrc    = wbLui;
                    end
                    beq: begin
                        ctrl.pcWrite = flags.zero;
                        ctrl.pcSrc   = pcAluOut;
                    end
                    bne: begin
                        ctrl.pcWrite = !flags.zero;
                        ctrl.pcSrc   = pcAluOut;
                    end
                    j: begin
                        ctrl.pcWrite = 1'b1;
                        ctrl.pcSrc   = pcJump;
                    end
                    default: begin
                        nextState = trapOpcode;
                    end
                endcase
            end
            aluWriteBack: begin
                // ALU recomputes so the overflow flag is live here
                ctrl.aluSrcA  = srcAReg;
                ctrl.aluSrcB  = execSrcB;
                ctrl.aluOp    = execOp;
                ctrl.regDst   = isRType ? dstRd : dstRt;
                ctrl.wbSrc    = wbAluOut;
                ctrl.regWrite = !ovfTrap;
                nextState     = ovfTrap ? trapOverflow : fetch;
            end
            memAccess: begin
                ctrl.busReq        = 1'b1;
                ctrl.busWe         = (opcode == sw);
                ctrl.busAdrFromAlu = 1'b1;
                if (busAck) begin
                    ctrl.mdrWrite = (opcode == lw);
                    nextState     = (opcode == lw) ? loadWriteBack : fetch;
                end
            end
            loadWriteBack: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstRt;
                ctrl.wbSrc    = wbMem;
                nextState     = fetch;
            end
            trapOverflow: begin
                ctrl.pcWrite = 1'b1;
                ctrl.pcSrc   = pcOvfVector;
                nextState    = fetch;
            end
            trapOpcode: begin
                ctrl.pcWrite = 1'b1;
                ctrl.pcSrc   = pcOpcVector;
                nextState    = fetch;
            end
            default: begin
                nextState = fetch;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= fetch;
            started <= 1'b0;
        end else begin
            state   <= nextState;
            started <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state) && state inside {fetch, decode, execute, aluWriteBack,
            memAccess, loadWriteBack, trapOverflow, trapOpcode})
        else $error("illegal FSM state %0d", state);

    assert property (@(posedge clk) disable iff (reset)
        !(ctrl.pcWrite && ctrl.regWrite))
        else $error("PC and register file written in the same cycle");

    // overflowed result never reaches the register file
    assert property (@(posedge clk) disable iff (reset)
        (state == trapOverflow) |-> $past(state == aluWriteBack && !ctrl.regWrite))
        else $error("overflow trap followed a register write");

endmodule

`default_nettype wire

//--- logic/dataPath.sv
`timescale 1ns/1ns
`default_nettype none

module dataPath #(
    parameter coreDefsPkg::word_t resetPc        = 32'h0000_0000,
    parameter coreDefsPkg::word_t overflowVector = 32'h0000_0100,
    parameter coreDefsPkg::word_t opcodeVector   = 32'h0000_0180
) (
    input  logic                   clk,
    input  logic                   reset,
    input  coreDefsPkg::ctrlWord_t ctrl,
    output coreDefsPkg::opcode_t   opcode,
    output coreDefsPkg::funct_t    funct,
    output coreDefsPkg::flags_t    flags,
    output logic                   busAck,
    output wbPkg::wbReq_t          wbOut,
    input  wbPkg::wbRsp_t          wbIn
);
    import coreDefsPkg::*;

    word_t    pc, ir, regA, regB, aluOut, mdr;
    word_t    rsData, rtData, immExt, aluA, aluB, aluResult, wrData, pcNext;
    regAddr_t wrAddr;

    assign opcode = opcode_t'(ir[31:26]);
    assign funct  = funct_t'(ir[5:0]);
    assign immExt = {{16{ir[15]}}, ir[15:0]};
    assign wrAddr = (ctrl.regDst == dstRd) ? ir[15:11] : ir[20:16];

    always_comb begin
        case (ctrl.wbSrc)
            wbMem:   wrData = mdr;
            wbSlt:   wrData = aluResult;
            wbLui:   wrData = {ir[15:0], 16'h0000};
            default: wrData = aluOut;
        endcase
    end

    regFile regs (
        .clk    (clk),
        .reset  (reset),
        .rs     (ir[25:21]),
        .rt     (ir[20:16]),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .wrEn   (ctrl.regWrite),
        .rsData (rsData),
        .rtData (rtData)
    );

    assign aluA = (ctrl.aluSrcA == srcAReg) ? regA : pc;

    always_comb begin
        case (ctrl.aluSrcB)
            srcBFour:     aluB = 32'd4;
            srcBImm:      aluB = immExt;
            srcBImmShift: aluB = {immExt[29:0], 2'b00};
            default:      aluB = regB;
        endcase
    end

    aluUnit alu (
        .a      (aluA),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .flags  (flags)
    );

    always_comb begin
        case (ctrl.pcSrc)
            pcAluOut:    pcNext = aluOut;
            pcJump:      pcNext = {pc[31:28], ir[25:0], 2'b00}; // pc already +4
            pcOvfVector: pcNext = overflowVector;
            pcOpcVector: pcNext = opcodeVector;
            default:     pcNext = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
            ir <= '0;
        end else begin
            if (ctrl.pcWrite) begin
                pc <= pcNext;
            end
            if (ctrl.irWrite) begin
                ir <= wbIn.dat;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.abWrite) begin
            regA <= rsData;
            regB <= rtData;
        end
        if (ctrl.aluOutWrite) begin
            aluOut <= aluResult;
        end
        if (ctrl.mdrWrite) begin
            mdr <= wbIn.dat;
        end
    end

    // classic master, request held by the FSM until ack
    assign wbOut.cyc = ctrl.busReq;
    assign wbOut.stb = ctrl.busReq;
    assign wbOut.we  = ctrl.busWe;
    assign wbOut.adr = ctrl.busAdrFromAlu ? aluOut : pc;
    assign wbOut.dat = regB;
    assign busAck    = wbIn.ack & ctrl.busReq;

    assert property (@(posedge clk) disable iff (reset)
        (wbOut.stb && !wbIn.ack) |=> (wbOut.stb && $stable(wbOut.adr) && $stable(wbOut.we)))
        else $error("bus request changed while waiting for ack");

endmodule

`default_nettype wire

//--- logic/mipsCore.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCore #(
    parameter coreDefsPkg::word_t resetPc        = 32'h0000_0000,
    parameter coreDefsPkg::word_t overflowVector = 32'h0000_0100,
    parameter coreDefsPkg::word_t opcodeVector   = 32'h0000_0180
) (
    input  logic          clk,
    input  logic          reset,
    output wbPkg::wbReq_t wbOut,
    input  wbPkg::wbRsp_t wbIn
);
    import coreDefsPkg::*;

    ctrlWord_t ctrl;
    opcode_t   opcode;
    funct_t    funct;
    flags_t    flags;
    logic      busAck;

    ctrlFsm fsm (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .flags  (flags),
        .busAck (busAck),
        .ctrl   (ctrl)
    );

    dataPath #(
        .resetPc        (resetPc),
        .overflowVector (overflowVector),
        .opcodeVector   (opcodeVector)
    ) dp (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (ctrl),
        .opcode (opcode),
        .funct  (funct),
        .flags  (flags),
        .busAck (busAck),
        .wbOut  (wbOut),
        .wbIn   (wbIn)
    );

endmodule

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic                  clk,
    input  logic                  reset,
    input  coreDefsPkg::regAddr_t rs,
    input  coreDefsPkg::regAddr_t rt,
    input  coreDefsPkg::regAddr_t wrAddr,
    input  coreDefsPkg::word_t    wrData,
    input  logic                  wrEn,
    output coreDefsPkg::word_t    rsData,
    output coreDefsPkg::word_t    rtData
);
    import coreDefsPkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin // $zero is read only
            regs[wrAddr] <= wrData;
        end
    end

    assign rsData = regs[rs];
    assign rtData = regs[rt];

    assert property (@(posedge clk) disable iff (reset)
        ((rs != '0) || (rsData == '0)) && ((rt != '0) || (rtData == '0)))
        else $error("register zero read nonzero");

endmodule

`default_nettype wire

//--- logic/wbPkg.sv
`default_nettype none

package wbPkg;

    localparam int adrWidth = 32;
    localparam int datWidth = 32;

    // master side of classic single transfers
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [adrWidth-1:0] adr;
        logic [datWidth-1:0] dat;
    } wbReq_t;

    typedef struct packed {
        logic                ack;
        logic [datWidth-1:0] dat; // valid with ack on reads
    } wbRsp_t;

endpackage

`default_nettype wire

//--- mipsCore.f
logic/coreDefsPkg.sv
logic/wbPkg.sv
logic/aluUnit.sv
logic/regFile.sv
logic/ctrlFsm.sv
logic/dataPath.sv
logic/mipsCore.sv
tb/mipsCoreTb.sv

//--- tb/mipsCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCoreTb;
    import wbPkg::*;

    localparam logic [31:0] resetPc        = 32'h0000_0000;
    localparam logic [31:0] overflowVector = 32'h0000_0100;
    localparam logic [31:0] opcodeVector   = 32'h0000_0180;
    localparam logic [31:0] finalMarkerAdr = 32'h0000_0288;
    localparam int          cycleLimit     = 4000;

    // MIPS encodings used by the program
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opSlti  = 6'h0a;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;
    localparam logic [5:0] fnAdd   = 6'h20;
    localparam logic [5:0] fnSub   = 6'h22;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnSlt   = 6'h2a;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    wbReq_t      wbOut;
    wbRsp_t      wbIn;
    logic [31:0] mem [256];
    logic [31:0] expWord [256];  // expected store data per word
    logic        expValid [256];
    logic        seen [256];
    logic [31:0] nextExp [256];  // expected next fetch after a given fetch
    logic        chkNext [256];
    logic [31:0] loadAdr;
    logic [31:0] prevFetch = 32'h0000_03FC;
    logic        pending = 1'b0;
    logic        finalSeen = 1'b0;
    logic        fetchAck;
    int          waitLeft = 0;
    int          cycles = 0;

    mipsCore uut (
        .clk   (clk),
        .reset (reset),
        .wbOut (wbOut),
        .wbIn  (wbIn)
    );

    always #2 clk = ~clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic logic [31:0] sext16(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encJ(input logic [31:0] target);
        return {opJ, target[27:2]};
    endfunction

    function automatic int missingStores();
        int n;
        n = 0;
        for (int i = 0; i < 256; i++) begin
            if (expValid[i] && !seen[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic put(input logic [31:0] instr);
        mem[loadAdr[9:2]] = instr;
        loadAdr = loadAdr + 4;
    endtask

    task automatic expectStore(input logic [31:0] adr, input logic [31:0] value);
        expValid[adr[9:2]] = 1'b1;
        expWord[adr[9:2]]  = value;
    endtask

    task automatic expectNext(input logic [31:0] from, input logic [31:0] to);
        chkNext[from[9:2]] = 1'b1;
        nextExp[from[9:2]] = to;
    endtask

    task automatic loadProgram();
        logic [31:0] res [1:9];
        logic [31:0] loadWord, r13, r14, undefAdr;
        for (int i = 0; i < 256; i++) begin
            mem[i]      = 32'hFC00_0000 | i; // unused opcode 0x3f everywhere
            expValid[i] = 1'b0;
            seen[i]     = 1'b0;
            chkNext[i]  = 1'b0;
        end
        res[1] = sext16(16'h1234);
        res[2] = sext16(16'hFF00);
        res[3] = {16'h8001, 16'h0000};
        res[4] = res[1] + res[2];
        res[5] = res[1] - res[2];
        res[6] = res[1] & res[2];
        res[7] = ($signed(res[3]) < $signed(res[1])) ? 32'd1 : 32'd0;
        res[8] = ($signed(res[1]) < $signed(sext16(16'h1000))) ? 32'd1 : 32'd0;
        res[9] = ($signed(res[2]) < $signed(sext16(16'hFFFF))) ? 32'd1 : 32'd0;
        loadAdr = resetPc;
        put(encI(opAddi, 5'd0, 5'd1, 16'h1234));
        put(encI(opAddiu, 5'd0, 5'd2, 16'hFF00));
        put(encI(opLui, 5'd0, 5'd3, 16'h8001));
        put(encR(5'd1, 5'd2, 5'd4, fnAdd));
        put(encR(5'd1, 5'd2, 5'd5, fnSub));
        put(encR(5'd1, 5'd2, 5'd6, fnAnd));
        put(encR(5'd3, 5'd1, 5'd7, fnSlt));
        put(encI(opSlti, 5'd1, 5'd8, 16'h1000));
        put(encI(opSlti, 5'd2, 5'd9, 16'hFFFF));
        for (int k = 1; k <= 9; k++) begin
            put(encI(opSw, 5'd0, 5'(k), 16'(32'h200 + 4 * (k - 1))));
            expectStore(32'h200 + 4 * (k - 1), res[k]);
        end
        // load, add, store back
        loadWord = 32'h1357_9BDF;
        mem[32'h300 >> 2] = loadWord;
        put(encI(opLw, 5'd0, 5'd10, 16'h0300));
        put(encR(5'd10, 5'd1, 5'd11, fnAdd));
        put(encI(opSw, 5'd0, 5'd11, 16'h0224));
        expectStore(32'h224, loadWord + res[1]);
        put(encI(opAddiu, 5'd0, 5'd12, 16'h00B1));
        put(encI(opBeq, 5'd1, 5'd1, 16'd1));
        put(encI(opSw, 5'd0, 5'd12, 16'h0240)); // skipped
        put(encI(opSw, 5'd0, 5'd12, 16'h0244));
        put(encI(opBeq, 5'd1, 5'd2, 16'd1));
        put(encI(opSw, 5'd0, 5'd12, 16'h0248));
        put(encI(opBne, 5'd1, 5'd2, 16'd1));
        put(encI(opSw, 5'd0, 5'd12, 16'h024C)); // skipped
        put(encI(opSw, 5'd0, 5'd12, 16'h0250));
        put(encI(opBne, 5'd1, 5'd1, 16'd1));
        put(encI(opSw, 5'd0, 5'd12, 16'h0254));
        put(encJ(loadAdr + 8));
        put(encI(opSw, 5'd0, 5'd12, 16'h0258)); // skipped
        put(encI(opSw, 5'd0, 5'd12, 16'h025C));
        expectStore(32'h244, sext16(16'h00B1));
        expectStore(32'h248, sext16(16'h00B1));
        expectStore(32'h250, sext16(16'h00B1));
        expectStore(32'h254, sext16(16'h00B1));
        expectStore(32'h25C, sext16(16'h00B1));
        r13 = {16'h7FFF, 16'h0000} + sext16(16'h7FFF);
        r14 = r13 + sext16(16'h7FFF) + sext16(16'h7FFF);
        put(encI(opLui, 5'd0, 5'd13, 16'h7FFF));
        put(encI(opAddiu, 5'd13, 5'd13, 16'h7FFF));
        put(encI(opAddiu, 5'd13, 5'd14, 16'h7FFF));
        expectNext(loadAdr, loadAdr + 4);
        put(encI(opAddiu, 5'd14, 5'd14, 16'h7FFF)); // wraps signed without a trap
        put(encI(opSw, 5'd0, 5'd14, 16'h0260));
        expectStore(32'h260, r14);
        expectNext(loadAdr, overflowVector);
        put(encR(5'd13, 5'd13, 5'd15, fnAdd));
        put(encI(opSw, 5'd0, 5'd15, 16'h0264)); // never reached
        undefAdr = loadAdr;
        expectNext(loadAdr, opcodeVector);
        put(32'hFC00_0000);
        // overflow handler goes on to the undefined opcode
        loadAdr = overflowVector;
        put(encI(opAddiu, 5'd0, 5'd16, 16'h00E1));
        put(encI(opSw, 5'd0, 5'd16, 16'h0280));
        put(encI(opSw, 5'd0, 5'd15, 16'h0284)); // add target kept its reset value
        put(encJ(undefAdr));
        expectStore(32'h280, sext16(16'h00E1));
        expectStore(32'h284, 32'h0);
        loadAdr = opcodeVector;
        put(encI(opAddiu, 5'd0, 5'd17, 16'h00E2));
        put(encI(opSw, 5'd0, 5'd17, 16'h0288));
        put(encJ(loadAdr));
        expectStore(finalMarkerAdr, sext16(16'h00E2));
    endtask

    task automatic serveRequest();
        if (wbOut.we) begin
            mem[wbOut.adr[9:2]]  = wbOut.dat;
            seen[wbOut.adr[9:2]] = 1'b1;
            if (wbOut.adr == finalMarkerAdr) begin
                finalSeen = 1'b1;
            end
        end else begin
            wbIn.dat = mem[wbOut.adr[9:2]];
        end
    endtask

    // slave with 0 to 3 wait states per transfer
    always @(posedge clk) begin
        #1;
        wbIn.ack = 1'b0;
        if (reset || !wbOut.stb) begin
            pending = 1'b0;
        end else begin
            if (!pending) begin
                pending  = 1'b1;
                waitLeft = $urandom_range(3, 0);
            end
            if (waitLeft == 0) begin
                serveRequest();
                wbIn.ack = 1'b1;
                pending  = 1'b0;
            end else begin
                waitLeft = waitLeft - 1;
            end
        end
    end

    assign fetchAck = wbOut.stb && wbIn.ack && !wbOut.we && (wbOut.adr < 32'h200);

    always @(posedge clk) begin
        if (fetchAck) begin
            prevFetch <= wbOut.adr;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            failRun($sformatf("timeout, no final marker store within %0d cycles", cycleLimit));
        end
    end

    assert property (@(posedge clk) reset |-> !wbOut.cyc && !wbOut.stb && !wbOut.we)
        else failRun("bus request raised while reset is high");

    assert property (@(posedge clk) $fell(reset) |-> !wbOut.cyc && !wbOut.stb && !wbOut.we)
        else failRun("bus request raised in the first cycle after reset");

    assert property (@(posedge clk) $fell(reset) |=> wbOut.cyc && wbOut.stb && !wbOut.we)
        else failRun("first bus request after reset is not a read");

    assert property (@(posedge clk) $fell(reset) |=> wbOut.adr == resetPc)
        else failRun($sformatf("Mismatch at %0t: first fetch at %h, expected %h",
            $time, $sampled(wbOut.adr), resetPc));

    assert property (@(posedge clk) disable iff (reset) wbOut.stb |-> wbOut.cyc)
        else failRun("strobe raised without cycle");

    assert property (@(posedge clk) disable iff (reset)
        (wbOut.stb && !wbIn.ack) |=> wbOut.stb && $stable(wbOut.adr)
            && $stable(wbOut.we) && $stable(wbOut.dat))
        else failRun("bus request dropped or changed before ack");

    assert property (@(posedge clk) disable iff (reset)
        (wbOut.stb && wbOut.we && wbIn.ack) |->
            (wbOut.adr < 32'h400) && expValid[wbOut.adr[9:2]])
        else failRun($sformatf("store to address %h that the program must not write",
            $sampled(wbOut.adr)));

    assert property (@(posedge clk) disable iff (reset)
        (wbOut.stb && wbOut.we && wbIn.ack && wbOut.adr < 32'h400) |->
            wbOut.dat == expWord[wbOut.adr[9:2]])
        else failRun($sformatf("Mismatch at %0t: store to %h carried %h, expected %h",
            $time, $sampled(wbOut.adr), $sampled(wbOut.dat),
            expWord[$sampled(wbOut.adr[9:2])]));

    assert property (@(posedge clk) disable iff (reset)
        (fetchAck && chkNext[prevFetch[9:2]]) |-> wbOut.adr == nextExp[prevFetch[9:2]])
        else failRun($sformatf("Mismatch at %0t: fetch after %h went to %h, expected %h",
            $time, $sampled(prevFetch), $sampled(wbOut.adr),
            nextExp[$sampled(prevFetch[9:2])]));

    initial begin
        wbIn = '0;
        void'($urandom(20153));
        loadProgram();
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        wait (finalSeen);
        repeat (2) @(posedge clk);
        if (missingStores() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            failRun($sformatf("%0d expected stores never happened", missingStores()));
        end
    end

endmodule

`default_nettype wire
